//--- list.f
cpuPkg.sv
alu.sv
registerFile.sv
busMux.sv
dataPath.sv
controlUnit.sv
miniCpu.sv
tbClock.sv
miniCpu_properties.sv
tbMiniCpu.sv

//--- runSim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tbMiniCpu -o simMiniCpu
./obj_dir/simMiniCpu | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

//--- tbMiniCpu.sv
module tbMiniCpu;
	import cpuPkg::*;

	localparam int addrWidth = 8;
	localparam int progLen = 40;
	localparam int numTests = 6;
	localparam int limit = numTests * (progLen + 1) * 8 * 10 + numTests * 100 * 10;
	localparam logic [4:0] arithOps [6] = '{opAdd, opSub, opAnd, opOr, opNeg, opNot};
	localparam logic [4:0] shiftOps [5] = '{opShr, opShra, opShl, opRor, opRol};

	logic                 Clock;
	logic                 rst;
	logic [addrWidth-1:0] memAddr;
	logic                 memRead;
	logic [31:0]          memData;
	logic [31:0]          outData;
	logic                 outValid;
	logic                 halted;

	logic [31:0] mem [2 ** addrWidth];
	logic [31:0] lfsr = 32'hef5b9b6f;
	logic [31:0] expQ [$];
	logic [31:0] expected;
	string       testName;
	int          errors;
	int          testErrors;
	int          passCount;
	int          outCount;
	int          expCount;

	tbClock clkGen (.Clock(Clock));

	miniCpu #(.addrWidth(addrWidth)) uut (.*);

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [31:0] shiftOf(input logic [4:0] op, input logic [31:0] x,
		input logic [4:0] n);
		case (op)
			opShr:   return x >> n;
			opShra:  return $signed(x) >>> n;
			opShl:   return x << n;
			opRor:   return (x >> n) | (x << (6'd32 - {1'b0, n}));
			default: return (x << n) | (x >> (6'd32 - {1'b0, n}));
		endcase
	endfunction

	task automatic genProgram(input int kind);
		logic [4:0] op;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [3:0] last;
		int         slot;
		last = 4'd1;
		for (int a = 0; a < 2 ** addrWidth; a++) begin
			mem[a[addrWidth-1:0]] = {opHalt, 27'(a)}; // halt tagged with its address
		end
		for (int i = 0; i < progLen - 1; i++) begin
			slot = (kind == 3) ? (i + 2) % 5 : i % 2;
			ra = 4'(randBits(3) + 1);
			rb = 4'(randBits(3) + 1);
			rc = 4'(randBits(3) + 1);
			case (kind)
				0: begin
					op = opAddi;
					rb = 4'(randBits(4));
				end
				1: op = arithOps[3'(randBits(3) % 6)];
				2: op = shiftOps[3'(randBits(3) % 5)];
				3: op = randBits(1) == 1 ? opDiv : opMul;
				default: op = 5'(randBits(4) % 14);
			endcase
			if (kind >= 3 && randBits(2) == 0)
				rc = 4'd0; // zero divisor or R0 source
			if (kind == 4 && randBits(1) == 1)
				ra = 4'd0;
			if (kind == 4 && randBits(2) == 0)
				rb = 4'd0;
			if (kind == 5) begin
				mem[i[addrWidth-1:0]] = randBits(32); // unknown opcodes included
			end else if (kind != 0 && i < 8) begin
				mem[i[addrWidth-1:0]] = {opAddi, 4'(i + 1), 4'd0, 19'(randBits(19))};
			end else if (slot == 0) begin
				mem[i[addrWidth-1:0]] = {op, ra, rb,
					(op == opAddi) ? 19'(randBits(19)) : {rc, 15'(randBits(15))}};
				last = ra;
			end else if (kind == 3 && (slot == 1 || slot == 3)) begin
				mem[i[addrWidth-1:0]] = {(slot == 1) ? opMfhi : opMflo, ra, 23'd0};
				last = ra;
			end else begin
				mem[i[addrWidth-1:0]] = {opOut, last, 23'd0};
			end
		end
		mem[addrWidth'(progLen - 1)] = {opHalt, 27'd0};
	endtask

	task automatic runModel();
		logic [31:0]          r [16];
		logic [31:0]          hi;
		logic [31:0]          lo;
		logic [31:0]          w;
		logic [31:0]          b;
		logic [31:0]          c;
		logic [31:0]          res;
		logic [63:0]          prod;
		logic [4:0]           op;
		logic                 wr;
		logic [addrWidth-1:0] pc;
		r = '{default: 32'd0};
		hi = '0;
		lo = '0;
		pc = '0;
		res = '0;
		expQ.delete();
		for (int k = 0; k < 2 ** addrWidth; k++) begin
			w = mem[pc];
			pc = pc + 1'b1;
			op = w[31:27];
			b = (w[22:19] == 4'd0) ? 32'd0 : r[w[22:19]];
			c = (w[18:15] == 4'd0) ? 32'd0 : r[w[18:15]];
			wr = 1'b1;
			case (op)
				opAdd:  res = b + c;
				opSub:  res = b - c;
				opAnd:  res = b & c;
				opOr:   res = b | c;
				opShr, opShra, opShl, opRor, opRol: res = shiftOf(op, b, c[4:0]);
				opNeg:  res = -b;
				opNot:  res = ~b;
				opAddi: res = b + {{13{w[18]}}, w[18:0]};
				opMfhi: res = hi;
				opMflo: res = lo;
				opMul: begin
					prod = 64'($signed(b)) * 64'($signed(c));
					hi = prod[63:32];
					lo = prod[31:0];
					wr = 1'b0;
				end
				opDiv: begin
					if (c == 32'd0) begin
						hi = b;
						lo = 32'hffffffff;
					end else begin
						hi = $signed(b) % $signed(c);
						lo = $signed(b) / $signed(c);
					end
					wr = 1'b0;
				end
				opOut: begin
					expQ.push_back((w[26:23] == 4'd0) ? 32'd0 : r[w[26:23]]);
					wr = 1'b0;
				end
				opHalt: return;
				default: wr = 1'b0; // no-op
			endcase
			if (wr && w[26:23] != 4'd0)
				r[w[26:23]] = res;
		end
	endtask

	task automatic runTest(input int kind, input string name);
		testName = name;
		testErrors = 0;
		genProgram(kind);
		runModel();
		expCount = expQ.size();
		@(posedge Clock);
		#1 rst = 1'b1;
		repeat (2) @(posedge Clock);
		#1 rst = 1'b0;
		outCount = 0;
		while (!halted)
			@(negedge Clock);
		repeat (50) begin
			@(negedge Clock);
			assert (!memRead) else begin
				$display("%s: memory read seen after halt", name);
				testErrors++;
			end
		end
		assert (outCount == expCount) else begin
			$display("ERR %s out count expected %0d actual %0d", name, expCount, outCount);
			testErrors++;
		end
		$display("%s: %s, %0d outputs", name, (testErrors == 0) ? "ok" : "FAILED", outCount);
		errors += testErrors;
		if (testErrors == 0)
			passCount++;
	endtask

	// instruction memory answers one cycle after the read strobe
	always @(posedge Clock) begin
		#1;
		if (memRead)
			memData = mem[memAddr];
	end

	always @(negedge Clock) begin
		if (!rst && outValid) begin
			outCount++;
			assert (expQ.size() != 0) else begin
				$display("%s: output pulse with no expected value left", testName);
				testErrors++;
			end
			if (expQ.size() != 0) begin
				expected = expQ.pop_front();
				assert (outData == expected) else begin
					$display("ERR %s expected %h actual %h", testName, expected, outData);
					testErrors++;
				end
			end
		end
	end

	initial begin
		#(limit);
		$display("watchdog: run did not finish within %0d time units", limit);
		$display("tests failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		memData = '0;
		errors = 0;
		passCount = 0;
		runTest(0, "immediates");
		runTest(1, "logicArith");
		runTest(2, "shiftRotate");
		runTest(3, "mulDiv");
		runTest(4, "zeroReg");
		runTest(5, "haltRandom");
		$display("summary: %0d of %0d clean, %0d errors", passCount, numTests, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- miniCpu_properties.sv
module miniCpuProperties (
	input logic Clock,
	input logic rst,
	input logic memRead,
	input logic outValid,
	input logic halted
);

	outPulse: assert property (@(posedge Clock) disable iff (rst)
		outValid |-> !$past(outValid))
		else $error("outValid held for two cycles");

	// halt is sticky and stops all fetches
	noReadHalted: assert property (@(posedge Clock) disable iff (rst)
		halted |=> halted && !memRead)
		else $error("halt dropped or memory read after halt");

	// a read needs the two cycles before it free of reads
	readSpacing: assert property (@(posedge Clock) disable iff (rst)
		memRead |-> !$past(memRead) && !$past(memRead, 2))
		else $error("memory reads too close together");

endmodule

bind miniCpu miniCpuProperties props (
	.Clock   (Clock),
	.rst     (rst),
	.memRead (memRead),
	.outValid(outValid),
	.halted  (halted)
);

//--- tbClock.sv
module tbClock #(
	parameter int period = 10
) (
	output logic Clock
);

	initial Clock = 1'b0;

	always #(period / 2) Clock = ~Clock;

endmodule

//--- miniCpu.sv
module miniCpu #(
	parameter int addrWidth = 8
) (
	input  logic                 Clock,
	input  logic                 rst,
	output logic [addrWidth-1:0] memAddr,
	output logic                 memRead,
	input  logic [31:0]          memData,
	output logic [31:0]          outData,
	output logic                 outValid,
	output logic                 halted
);
	import cpuPkg::*;

	ctrlT  ctrl;
	instrT ir;

	controlUnit ctrlUnit (
		.Clock(Clock),
		.rst  (rst),
		.ir   (ir),
		.ctrl (ctrl)
	);

	dataPath #(.addrWidth(addrWidth)) dp (
		.Clock   (Clock),
		.rst     (rst),
		.ctrl    (ctrl),
		.memData (memData),
		.ir      (ir),
		.memAddr (memAddr),
		.memRead (memRead),
		.outData (outData),
		.outValid(outValid),
		.halted  (halted)
	);

endmodule

//--- controlUnit.sv
module controlUnit (
	input  logic          Clock,
	input  logic          rst,
	input  cpuPkg::instrT ir,
	output cpuPkg::ctrlT  ctrl
);
	import cpuPkg::*;

	logic [2:0] step;
	logic [2:0] lastStep;
	logic       haltState;
	logic       nopFetch;

	function automatic aluOpT aluOpOf(input opcodeT op);
		case (op)
			opSub:   return aluSub;
			opAnd:   return aluAnd;
			opOr:    return aluOr;
			opShr:   return aluShr;
			opShra:  return aluShra;
			opShl:   return aluShl;
			opRor:   return aluRor;
			opRol:   return aluRol;
			opMul:   return aluMul;
			opDiv:   return aluDiv;
			opNeg:   return aluNeg;
			opNot:   return aluNot;
			default: return aluAdd; // add and addi
		endcase
	endfunction

	always_comb begin
		case (ir.op)
			opMul, opDiv:                             lastStep = 3'd7;
			opAdd, opSub, opAnd, opOr, opAddi:        lastStep = 3'd6;
			opShr, opShra, opShl, opRor, opRol:       lastStep = 3'd6;
			opNeg, opNot:                             lastStep = 3'd5;
			opMfhi, opMflo, opOut, opHalt:            lastStep = 3'd4;
			default:                                  lastStep = 3'd3; // unknown opcode
		endcase
	end

	// a no-op is only known once IR is loaded, so its T4 slot is the next T0
	assign nopFetch = (step == 3'd4) && (lastStep == 3'd3);

	always_comb begin
		ctrl = '0;
		ctrl.busSrc = srcNone;
		ctrl.regSel = selRa;
		ctrl.aluOp = aluPassB;
		if (haltState) begin
			ctrl.halt = 1'b1;
		end else if (step == 3'd0 || nopFetch) begin
			ctrl.busSrc = srcPc;
			ctrl.marIn = 1'b1;
			ctrl.incPc = 1'b1;
			ctrl.aluOp = aluAdd;
			ctrl.zIn = 1'b1;
		end else if (step == 3'd1) begin
			ctrl.busSrc = srcZlo;
			ctrl.pcIn = 1'b1;
			ctrl.memRead = 1'b1;
		end else if (step == 3'd2) begin
			ctrl.mdrIn = 1'b1;
		end else if (step == 3'd3) begin
			ctrl.busSrc = srcMdr;
			ctrl.irIn = 1'b1;
		end else begin
			case (ir.op)
				opNeg, opNot: begin
					if (step == 3'd4) begin
						ctrl.busSrc = srcGpr;
						ctrl.regSel = selRb;
						ctrl.aluOp = aluOpOf(ir.op);
						ctrl.zIn = 1'b1;
					end else begin
						ctrl.busSrc = srcZlo;
						ctrl.regWrite = 1'b1;
					end
				end
				opMfhi, opMflo: begin
					ctrl.busSrc = (ir.op == opMfhi) ? srcHi : srcLo;
					ctrl.regWrite = 1'b1;
				end
				opOut: begin
					ctrl.busSrc = srcGpr;
					ctrl.outIn = 1'b1;
				end
				opHalt: ctrl.halt = 1'b1;
				opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol,
				opAddi, opMul, opDiv: begin
					case (step)
						3'd4: begin
							ctrl.busSrc = srcGpr;
							ctrl.regSel = selRb;
							ctrl.yIn = 1'b1;
						end
						3'd5: begin
							ctrl.busSrc = (ir.op == opAddi) ? srcImm : srcGpr;
							ctrl.regSel = selRc;
							ctrl.aluOp = aluOpOf(ir.op);
							ctrl.zIn = 1'b1;
						end
						3'd6: begin
							ctrl.busSrc = srcZlo;
							if (ir.op == opMul || ir.op == opDiv)
								ctrl.loIn = 1'b1;
							else
								ctrl.regWrite = 1'b1;
						end
						default: begin
							ctrl.busSrc = srcZhi; // T7, mul and div only
							ctrl.hiIn = 1'b1;
						end
					endcase
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			step <= 3'd0;
			haltState <= 1'b0;
		end else if (ctrl.halt) begin
			step <= 3'd0;
			haltState <= 1'b1; // held until reset
		end else if (nopFetch) begin
			step <= 3'd1;
		end else if (step >= 3'd4 && step == lastStep) begin
			step <= 3'd0;
		end else begin
			step <= step + 3'd1;
		end
	end

endmodule

//--- dataPath.sv
module dataPath #(
	parameter int addrWidth = 8
) (
	input  logic                 Clock,
	input  logic                 rst,
	input  cpuPkg::ctrlT         ctrl,
	input  logic [31:0]          memData,
	output cpuPkg::instrT        ir,
	output logic [addrWidth-1:0] memAddr,
	output logic                 memRead,
	output logic [31:0]          outData,
	output logic                 outValid,
	output logic                 halted
);
	import cpuPkg::*;

	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] mar;
	logic [31:0]          y;
	logic [31:0]          zlo;
	logic [31:0]          zhi;
	logic [31:0]          hi;
	logic [31:0]          lo;
	logic [31:0]          mdr;
	logic [31:0]          bus;
	logic [31:0]          regOut;
	logic [31:0]          aluA;
	logic [63:0]          aluOut;

	assign aluA = ctrl.incPc ? 32'd1 : y; // constant 1 for PC increment
	assign memAddr = mar;

	always_ff @(posedge Clock) begin
		if (rst) begin
			pc <= '0;
			mar <= '0;
			ir <= '0;
			y <= '0;
			zlo <= '0;
			zhi <= '0;
			hi <= '0;
			lo <= '0;
			mdr <= '0;
			outData <= '0;
			outValid <= 1'b0;
			memRead <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (ctrl.pcIn)
				pc <= bus[addrWidth-1:0];
			if (ctrl.marIn)
				mar <= bus[addrWidth-1:0];
			if (ctrl.irIn)
				ir <= instrT'(bus);
			if (ctrl.yIn)
				y <= bus;
			if (ctrl.zIn) begin
				zlo <= aluOut[31:0];
				zhi <= aluOut[63:32];
			end
			if (ctrl.hiIn)
				hi <= bus;
			if (ctrl.loIn)
				lo <= bus;
			if (ctrl.mdrIn)
				mdr <= memData; // word requested at T1
			if (ctrl.outIn)
				outData <= bus;
			outValid <= ctrl.outIn;
			memRead <= ctrl.memRead;
			halted <= ctrl.halt;
		end
	end

	registerFile gpr (
		.Clock   (Clock),
		.rst     (rst),
		.ir      (ir),
		.regSel  (ctrl.regSel),
		.regWrite(ctrl.regWrite),
		.busIn   (bus),
		.regOut  (regOut)
	);

	busMux #(.addrWidth(addrWidth)) busSel (
		.busSrc(ctrl.busSrc),
		.pc    (pc),
		.mdr   (mdr),
		.zlo   (zlo),
		.zhi   (zhi),
		.hi    (hi),
		.lo    (lo),
		.regOut(regOut),
		.imm   (ir.low.imm),
		.bus   (bus)
	);

	alu aluUnit (
		.a     (aluA),
		.b     (bus),
		.op    (ctrl.aluOp),
		.result(aluOut)
	);

endmodule

//--- busMux.sv
module busMux #(
	parameter int addrWidth = 8
) (
	input  cpuPkg::busSrcT       busSrc,
	input  logic [addrWidth-1:0] pc,
	input  logic [31:0]          mdr,
	input  logic [31:0]          zlo,
	input  logic [31:0]          zhi,
	input  logic [31:0]          hi,
	input  logic [31:0]          lo,
	input  logic [31:0]          regOut,
	input  logic [18:0]          imm,
	output logic [31:0]          bus
);
	import cpuPkg::*;

	always_comb begin
		case (busSrc)
			srcPc:   bus = 32'(pc); // zero-extended
			srcMdr:  bus = mdr;
			srcZlo:  bus = zlo;
			srcZhi:  bus = zhi;
			srcHi:   bus = hi;
			srcLo:   bus = lo;
			srcGpr:  bus = regOut;
			srcImm:  bus = {{13{imm[18]}}, imm};
			default: bus = '0; // nothing driving
		endcase
	end

endmodule

//--- registerFile.sv
module registerFile (
	input  logic           Clock,
	input  logic           rst,
	input  cpuPkg::instrT  ir,
	input  cpuPkg::regSelT regSel,
	input  logic           regWrite,
	input  logic [31:0]    busIn,
	output logic [31:0]    regOut
);
	import cpuPkg::*;

	logic [31:0] regs [16];
	logic [3:0]  idx;

	always_comb begin
		case (regSel)
			selRb:   idx = ir.rb;
			selRc:   idx = ir.low.reg3.rc;
			default: idx = ir.ra;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && idx != 4'd0) begin // R0 writes dropped
			regs[idx] <= busIn;
		end
	end

	assign regOut = (idx == 4'd0) ? 32'd0 : regs[idx];

endmodule

//--- alu.sv
module alu (
	input  logic [31:0]   a,
	input  logic [31:0]   b,
	input  cpuPkg::aluOpT op,
	output logic [63:0]   result
);
	import cpuPkg::*;

	logic [4:0]  shamt;
	logic [63:0] product;
	logic [63:0] rotR;
	logic [63:0] rotL;
	logic [31:0] quot;
	logic [31:0] rem;
	logic [31:0] low32;

	assign shamt = b[4:0]; // only low five bits count
	assign product = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // low 64 bits are the signed product
	assign rotR = {a, a} >> shamt;
	assign rotL = {a, a} << shamt;

	always_comb begin
		if (b == 32'd0) begin
			quot = '1;
			rem = a;
		end else begin
			quot = $signed(a) / $signed(b);
			rem = $signed(a) % $signed(b);
		end
	end

	always_comb begin
		case (op)
			aluAdd:   low32 = a + b;
			aluSub:   low32 = a - b;
			aluAnd:   low32 = a & b;
			aluOr:    low32 = a | b;
			aluShr:   low32 = a >> shamt;
			aluShra:  low32 = $signed(a) >>> shamt;
			aluShl:   low32 = a << shamt;
			aluRor:   low32 = rotR[31:0];
			aluRol:   low32 = rotL[63:32];
			aluNeg:   low32 = -b;
			aluNot:   low32 = ~b;
			aluPassB: low32 = b;
			default:  low32 = '0; // mul and div use the wide path
		endcase
	end

	always_comb begin
		case (op)
			aluMul:  result = product;
			aluDiv:  result = {rem, quot}; // remainder goes to Zhi
			default: result = {32'd0, low32};
		endcase
	end

endmodule

//--- cpuPkg.sv
package cpuPkg;

	typedef enum logic [4:0] {
		opAdd  = 5'd0,
		opSub  = 5'd1,
		opAnd  = 5'd2,
		opOr   = 5'd3,
		opShr  = 5'd4,
		opShra = 5'd5,
		opShl  = 5'd6,
		opRor  = 5'd7,
		opRol  = 5'd8,
		opMul  = 5'd9,
		opDiv  = 5'd10,
		opNeg  = 5'd11,
		opNot  = 5'd12,
		opAddi = 5'd13,
		opMfhi = 5'd14,
		opMflo = 5'd15,
		opOut  = 5'd16,
		opHalt = 5'd17
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr,
		aluShr, aluShra, aluShl, aluRor, aluRol,
		aluMul, aluDiv, aluNeg, aluNot, aluPassB
	} aluOpT;

	typedef enum logic [3:0] {
		srcNone, srcPc, srcMdr, srcZlo, srcZhi, srcHi, srcLo, srcGpr, srcImm
	} busSrcT;

	typedef enum logic [1:0] {
		selRa, selRb, selRc
	} regSelT;

	// rc shares its bits with the top of the immediate
	typedef struct packed {
		logic [3:0]  rc;
		logic [14:0] spare;
	} rcFieldT;

	typedef union packed {
		rcFieldT            reg3;
		logic signed [18:0] imm;
	} lowFieldT;

	typedef struct packed {
		opcodeT     op;
		logic [3:0] ra;
		logic [3:0] rb;
		lowFieldT   low;
	} instrT;

	typedef struct packed {
		busSrcT busSrc;
		regSelT regSel;
		logic   regWrite;
		logic   pcIn;
		logic   marIn;
		logic   mdrIn;
		logic   irIn;
		logic   yIn;
		logic   zIn;
		logic   hiIn;
		logic   loIn;
		logic   outIn;
		logic   incPc;
		aluOpT  aluOp;
		logic   memRead;
		logic   halt;
	} ctrlT;

endpackage
